/* tb.f */
design/id_pkg.sv
design/if_id_latch.sv
design/register_bank.sv
design/control_unit.sv
design/field_extract.sv
design/id_ex_latch.sv
design/id_stage.sv
bench/tb_clock_gen.sv
bench/id_stage_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f tb.f --top-module id_stage_tb -o sim_id_stage
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_id_stage)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

/* bench/id_stage_tb.sv */
module id_stage_tb;

    import id_pkg::*;

    localparam int N_OPS          = 20;
    localparam int N_FNS          = 13;
    localparam int RESET_CYCLES   = 8;
    localparam int FLUSH_CYCLES   = 2;
    localparam int REG_CYCLES     = 64;
    localparam int FIELD_CYCLES   = 40;
    localparam int STALL_CYCLES   = 7;
    localparam int FREEZE_CYCLES  = 7;
    localparam int TOTAL_CYCLES   = 2 * RESET_CYCLES + N_OPS + N_FNS + REG_CYCLES
                                    + FIELD_CYCLES + STALL_CYCLES + FREEZE_CYCLES
                                    + 6 * FLUSH_CYCLES;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_CYCLES;

    localparam opcode_t OP_LIST [N_OPS] = '{
        OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LB, OP_LH, OP_LW,
        OP_SB, OP_SH, OP_SW, OP_BEQ, OP_BNE, OP_J, OP_JAL, OP_HALT,
        6'h01, 6'h10, 6'h3e                       // Outside the ISA
    };
    localparam funct_t FN_LIST [N_FNS] = '{
        FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLL, FN_SRL,
        FN_JR, FN_JALR, 6'h01, 6'h3f              // Last two unknown
    };

    logic      i_clock;
    logic      i_arst_n;
    logic      i_enable;
    logic      i_stall;
    inst_t     i_inst;
    pc_t       i_pc;
    wb_t       i_wb;
    reg_addr_t i_dbg_addr;
    id_ex_t    o_id_ex;
    data_t     o_dbg_data;
    logic      o_jr_jalr;
    pc_t       o_jr_target;

    inst_t       m_inst;                     // Model of the IF/ID latch
    pc_t         m_pc;
    data_t       ref_regs [REG_COUNT];
    id_ex_t      exp_q [$];                  // Newest at the front
    id_ex_t      exp_head = '0;
    id_ex_t      pred_next;
    data_t       exp_dbg;
    logic [31:0] lfsr_state = 32'h650310a1;
    int          cycle_count = 0;
    int          fail_id_ex = 0;
    int          fail_bubble = 0;
    int          fail_freeze = 0;
    int          fail_dbg = 0;
    int          fail_jr = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errs_at_start = 0;

    tb_clock_gen #(.P_PERIOD(10)) u_clock (.o_clock(i_clock));

    id_stage #(.P_WB_BYPASS(1'b1)) uut (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_enable(i_enable), .i_stall(i_stall),
        .i_inst(i_inst), .i_pc(i_pc), .i_wb(i_wb), .i_dbg_addr(i_dbg_addr),
        .o_id_ex(o_id_ex), .o_dbg_data(o_dbg_data), .o_jr_jalr(o_jr_jalr),
        .o_jr_target(o_jr_target)
    );

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
        return value;
    endfunction

    function automatic inst_t random_inst();
        inst_t w;
        int    idx;
        w   = rand_bits(32);
        idx = int'(rand_bits(6) % (N_OPS + N_FNS));
        if (idx < N_OPS) begin
            w[31:26] = OP_LIST[idx];
        end else begin
            w[31:26] = OP_RTYPE;
            w[5:0]   = FN_LIST[idx - N_OPS];
        end
        return w;
    endfunction

    function automatic ctrl_t predict_ctrl(input inst_t inst);
        ctrl_t   c;
        opcode_t op;
        funct_t  fn;
        c  = '0;
        op = inst[31:26];
        fn = inst[5:0];
        case (op)
            OP_RTYPE: begin
                c.reg_dest  = 1'b1;
                c.reg_write = (fn != FN_JR);
                c.jr_jalr   = (fn == FN_JR) || (fn == FN_JALR);
                c.link      = (fn == FN_JALR);
                case (fn)
                    FN_ADDU, FN_JR, FN_JALR: c.alu_op = ALU_ADD;
                    FN_SUBU: c.alu_op = ALU_SUB;
                    FN_AND:  c.alu_op = ALU_AND;
                    FN_OR:   c.alu_op = ALU_OR;
                    FN_XOR:  c.alu_op = ALU_XOR;
                    FN_NOR:  c.alu_op = ALU_NOR;
                    FN_SLT:  c.alu_op = ALU_SLT;
                    FN_SLL:  c.alu_op = ALU_SLL;
                    FN_SRL:  c.alu_op = ALU_SRL;
                    default: c = '0;
                endcase
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                c.alu_src   = 1'b1;
                c.reg_write = 1'b1;
                case (op)
                    OP_SLTI: c.alu_op = ALU_SLT;
                    OP_ANDI: c.alu_op = ALU_AND;
                    OP_ORI:  c.alu_op = ALU_OR;
                    OP_XORI: c.alu_op = ALU_XOR;
                    OP_LUI:  c.alu_op = ALU_LUI;
                    default: c.alu_op = ALU_ADD;
                endcase
            end
            OP_LB, OP_LH, OP_LW, OP_SB, OP_SH, OP_SW: begin
                c.alu_src     = 1'b1;
                c.alu_op      = ALU_ADD;
                c.mem_read    = !op[3];          // Bit 3 marks a store
                c.mem_to_reg  = !op[3];
                c.reg_write   = !op[3];
                c.mem_write   = op[3];
                c.byte_en     = (op[1:0] == 2'b00);
                c.halfword_en = (op[1:0] == 2'b01);
                c.word_en     = (op[1:0] == 2'b11);
            end
            OP_BEQ, OP_BNE: begin
                c.alu_op    = ALU_SUB;
                c.branch    = 1'b1;
                c.branch_ne = op[0];
            end
            OP_J: c.jump = 1'b1;
            OP_JAL: begin
                c.jump      = 1'b1;
                c.link      = 1'b1;
                c.reg_write = 1'b1;
            end
            OP_HALT: c.hlt = 1'b1;
            default: c = '0;
        endcase
        if (inst == '0) c = '0;                  // NOP word
        return c;
    endfunction

    function automatic data_t predict_imm(input inst_t inst);
        data_t imm;
        case (inst[31:26])
            OP_ANDI, OP_ORI, OP_XORI: imm = {16'h0000, inst[15:0]};
            OP_LUI:                   imm = {inst[15:0], 16'h0000};
            default:                  imm = {{16{inst[15]}}, inst[15:0]};
        endcase
        return imm;
    endfunction

    function automatic data_t read_model(input reg_addr_t a, input wb_t wb);
        if (a == '0) return '0;
        if (wb.reg_write && (wb.addr == a)) return wb.data;   // Write-through
        return ref_regs[a];
    endfunction

    function automatic id_ex_t predict_id_ex(input inst_t inst, input pc_t pc,
                                             input logic stall, input wb_t wb);
        id_ex_t e;
        e.ctrl      = stall ? '0 : predict_ctrl(inst);
        e.pc        = pc;
        e.data_a    = read_model(inst[25:21], wb);
        e.data_b    = read_model(inst[20:16], wb);
        e.immediate = predict_imm(inst);
        e.shamt     = {27'b0, inst[10:6]};
        e.jump_addr = {pc[31:28], 2'b00, inst[25:0]};
        e.rs        = inst[25:21];
        e.rt        = inst[20:16];
        e.rd        = inst[15:11];
        return e;
    endfunction

    function automatic int total_errors();
        return fail_id_ex + fail_bubble + fail_freeze + fail_dbg + fail_jr;
    endfunction

    always_comb begin
        pred_next = predict_id_ex(m_inst, m_pc, i_stall, i_wb);
        exp_dbg   = (i_dbg_addr == '0) ? '0 : ref_regs[i_dbg_addr];   // No write-through
    end

    always @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            exp_q.delete();
            exp_q.push_front('0);
            exp_q.push_front('0);
            m_inst <= '0;
            m_pc   <= '0;
            for (int i = 0; i < REG_COUNT; i++) begin
                ref_regs[i] <= '0;
            end
        end else begin
            exp_q.push_front(i_enable ? pred_next : exp_q[0]);
            if (exp_q.size() > 2) void'(exp_q.pop_back());
            if (i_enable && !i_stall) begin
                m_inst <= i_inst;
                m_pc   <= i_pc;
            end
            if (i_wb.reg_write && (i_wb.addr != '0)) ref_regs[i_wb.addr] <= i_wb.data;
        end
        exp_head = exp_q[0];
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    a_id_ex : assert property (@(negedge i_clock) o_id_ex == exp_head)
        else begin
            $display("Error: time %0t, o_id_ex is %h, expected %h", $time, o_id_ex, exp_head);
            fail_id_ex++;
        end

    a_bubble : assert property (@(negedge i_clock) disable iff (!i_arst_n)
        ($past(i_stall) && $past(i_enable)) |-> (o_id_ex.ctrl == '0))
        else begin
            $display("Error: time %0t, control not cleared on stall", $time);
            fail_bubble++;
        end

    a_freeze : assert property (@(negedge i_clock) disable iff (!i_arst_n)
        !$past(i_enable) |-> $stable(o_id_ex))
        else begin
            $display("Error: time %0t, o_id_ex changed while frozen", $time);
            fail_freeze++;
        end

    a_dbg : assert property (@(negedge i_clock) o_dbg_data == exp_dbg)
        else begin
            $display("Error: time %0t, debug read %h, expected %h", $time, o_dbg_data, exp_dbg);
            fail_dbg++;
        end

    a_jr : assert property (@(negedge i_clock)
        (o_jr_jalr == pred_next.ctrl.jr_jalr) && (o_jr_target == pred_next.data_a))
        else begin
            $display("Error: time %0t, jump-register outputs %b %h, expected %b %h", $time,
                     o_jr_jalr, o_jr_target, pred_next.ctrl.jr_jalr, pred_next.data_a);
            fail_jr++;
        end

    task automatic next_cycle();
        @(posedge i_clock);
        #1;                                      // Drive just after the edge
    endtask

    task automatic present(input inst_t w);
        i_inst = w;
        i_pc   = rand_bits(32);
        next_cycle();
    endtask

    task automatic set_wb(input logic we, input reg_addr_t a, input data_t d);
        i_wb.reg_write = we;
        i_wb.addr      = a;
        i_wb.data      = d;
    endtask

    task automatic end_test(input string name);
        int errs;
        i_inst = '0;
        i_wb   = '0;
        repeat (FLUSH_CYCLES) next_cycle();     // Let the last word reach the output
        errs = total_errors() - errs_at_start;
        $display("%s test finished, %0d assertion failures", name, errs);
        tests_run++;
        if (errs > 0) tests_failed++;
        errs_at_start = total_errors();
    endtask

    task automatic test_reset();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            i_dbg_addr = reg_addr_t'(i * 4 + 1);
            next_cycle();
        end
        i_arst_n = 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            i_dbg_addr = reg_addr_t'(i * 4 + 3);
            next_cycle();
        end
        end_test("reset");
    endtask

    task automatic test_decode();
        inst_t w;
        for (int i = 0; i < N_OPS; i++) begin
            w        = rand_bits(32);
            w[31:26] = OP_LIST[i];
            present(w);
        end
        for (int i = 0; i < N_FNS; i++) begin
            w        = rand_bits(32);
            w[31:26] = OP_RTYPE;
            w[5:0]   = FN_LIST[i];
            present(w);
        end
        end_test("decode table");
    endtask

    task automatic test_regfile();
        inst_t     w;
        reg_addr_t last_rs;
        last_rs = '0;
        for (int i = 0; i < REG_CYCLES; i++) begin
            w        = rand_bits(32);
            w[31:26] = OP_RTYPE;
            w[5:0]   = FN_ADDU;
            if (i % 5 == 0)
                set_wb(1'b1, '0, rand_bits(32));                  // r0 must stay zero
            else if (i % 3 == 0)
                set_wb(1'b1, last_rs, rand_bits(32));             // Hits the word in decode
            else
                set_wb(i % 8 != 7, reg_addr_t'(rand_bits(5)), rand_bits(32));
            i_dbg_addr = reg_addr_t'(rand_bits(5));
            last_rs    = w[25:21];
            present(w);
        end
        end_test("register file");
    endtask

    task automatic test_fields();
        for (int i = 0; i < FIELD_CYCLES; i++) begin
            set_wb(1'b1, reg_addr_t'(rand_bits(5)), rand_bits(32));
            i_dbg_addr = reg_addr_t'(rand_bits(5));
            present(random_inst());
        end
        end_test("fields");
    endtask

    task automatic test_stall();
        present({OP_ADDI, 5'd1, 5'd2, 16'h8001});
        present({OP_LW, 5'd3, 5'd4, 16'h0010});
        i_stall = 1'b1;
        repeat (3) present({OP_RTYPE, 5'd5, 5'd0, 5'd31, 5'd0, FN_JALR});   // Fetch holds
        i_stall = 1'b0;
        next_cycle();
        present({OP_SW, 5'd6, 5'd7, 16'hfff0});
        end_test("stall");
    endtask

    task automatic test_freeze();
        set_wb(1'b1, 5'd9, 32'h0000_4321);
        present({OP_RTYPE, 5'd9, 15'd0, FN_JR});
        i_wb     = '0;
        i_enable = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (i == 2) set_wb(1'b1, 5'd9, 32'h0000_8765);        // Target moves
            else i_wb = '0;
            present(random_inst());
        end
        i_wb     = '0;
        i_enable = 1'b1;
        present({OP_RTYPE, 5'd9, 5'd0, 5'd31, 5'd0, FN_JALR});
        end_test("debug freeze");
    endtask

    initial begin
        i_arst_n   = 1'b0;
        i_enable   = 1'b1;
        i_stall    = 1'b0;
        i_inst     = '0;
        i_pc       = '0;
        i_wb       = '0;
        i_dbg_addr = '0;
        test_reset();
        test_decode();
        test_regfile();
        test_fields();
        test_stall();
        test_freeze();
        $display("Tests run %0d, tests with errors %0d, assertion failures %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* bench/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int P_PERIOD = 10
) (
    output logic o_clock
);

    logic clock = 1'b0;

    always #(P_PERIOD / 2) clock = ~clock;   // 50% duty

    assign o_clock = clock;

endmodule

/* design/id_stage.sv */
module id_stage #(
    parameter bit P_WB_BYPASS = 1'b1
) (
    input  logic              i_clock,
    input  logic              i_arst_n,
    input  logic              i_enable,      // Debug unit
    input  logic              i_stall,       // Hazard unit
    input  id_pkg::inst_t     i_inst,
    input  id_pkg::pc_t       i_pc,          // PC+1 from fetch
    input  id_pkg::wb_t       i_wb,
    input  id_pkg::reg_addr_t i_dbg_addr,    // Debug unit
    output id_pkg::id_ex_t    o_id_ex,
    output id_pkg::data_t     o_dbg_data,
    output logic              o_jr_jalr,     // To fetch
    output id_pkg::pc_t       o_jr_target
);

    import id_pkg::*;

    inst_t     inst_q;
    pc_t       pc_q;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    data_t     immediate;
    data_t     shamt;
    pc_t       jump_addr;
    data_t     data_a;
    data_t     data_b;
    ctrl_t     ctrl;

    if_id_latch u_if_id (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_enable(i_enable), .i_stall(i_stall),
        .i_inst(i_inst), .i_pc(i_pc), .o_inst(inst_q), .o_pc(pc_q)
    );

    field_extract u_fields (
        .i_inst(inst_q), .i_pc(pc_q), .o_rs(rs), .o_rt(rt), .o_rd(rd),
        .o_immediate(immediate), .o_shamt(shamt), .o_jump_addr(jump_addr)
    );

    register_bank #(.P_WB_BYPASS(P_WB_BYPASS)) u_regs (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_wb(i_wb), .i_rs(rs), .i_rt(rt),
        .i_dbg_addr(i_dbg_addr), .o_data_a(data_a), .o_data_b(data_b),
        .o_dbg_data(o_dbg_data)
    );

    control_unit u_ctrl (
        .i_inst(inst_q), .i_stall(i_stall), .o_ctrl(ctrl)
    );

    id_ex_latch u_id_ex (
        .i_clock(i_clock), .i_arst_n(i_arst_n), .i_enable(i_enable), .i_ctrl(ctrl),
        .i_pc(pc_q), .i_data_a(data_a), .i_data_b(data_b), .i_immediate(immediate),
        .i_shamt(shamt), .i_jump_addr(jump_addr), .i_rs(rs), .i_rt(rt), .i_rd(rd),
        .o_id_ex(o_id_ex)
    );

    assign o_jr_jalr   = ctrl.jr_jalr;
    assign o_jr_target = data_a;   // rs holds the target

endmodule

/* design/id_ex_latch.sv */
module id_ex_latch (
    input  logic              i_clock,
    input  logic              i_arst_n,
    input  logic              i_enable,      // Low freezes the stage
    input  id_pkg::ctrl_t     i_ctrl,        // Already zero on stall
    input  id_pkg::pc_t       i_pc,
    input  id_pkg::data_t     i_data_a,
    input  id_pkg::data_t     i_data_b,
    input  id_pkg::data_t     i_immediate,
    input  id_pkg::data_t     i_shamt,
    input  id_pkg::pc_t       i_jump_addr,
    input  id_pkg::reg_addr_t i_rs,
    input  id_pkg::reg_addr_t i_rt,
    input  id_pkg::reg_addr_t i_rd,
    output id_pkg::id_ex_t    o_id_ex
);

    import id_pkg::*;

    id_ex_t id_ex_d;

    always_comb begin
        id_ex_d.ctrl      = i_ctrl;
        id_ex_d.pc        = i_pc;
        id_ex_d.data_a    = i_data_a;
        id_ex_d.data_b    = i_data_b;
        id_ex_d.immediate = i_immediate;
        id_ex_d.shamt     = i_shamt;
        id_ex_d.jump_addr = i_jump_addr;
        id_ex_d.rs        = i_rs;
        id_ex_d.rt        = i_rt;
        id_ex_d.rd        = i_rd;
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_id_ex <= '0;   // All controls inactive
        end else if (i_enable) begin
            o_id_ex <= id_ex_d;
        end
    end

    // The first word out of reset must not touch architectural state
    a_quiet_after_reset : assert property (@(posedge i_clock)
        $rose(i_arst_n) |=> (!o_id_ex.ctrl.reg_write && !o_id_ex.ctrl.mem_write))
        else $error("id_ex_latch: write control active right after reset");

endmodule

/* design/field_extract.sv */
module field_extract (
    input  id_pkg::inst_t     i_inst,
    input  id_pkg::pc_t       i_pc,         // PC+1
    output id_pkg::reg_addr_t o_rs,
    output id_pkg::reg_addr_t o_rt,
    output id_pkg::reg_addr_t o_rd,
    output id_pkg::data_t     o_immediate,
    output id_pkg::data_t     o_shamt,
    output id_pkg::pc_t       o_jump_addr
);

    import id_pkg::*;

    opcode_t     opcode;
    logic [15:0] imm16;

    assign opcode = i_inst[31:26];
    assign imm16  = i_inst[15:0];

    always_comb begin
        case (opcode)
            OP_ANDI, OP_ORI, OP_XORI: o_immediate = {16'b0, imm16};   // Logical ops zero-extend
            OP_LUI:                   o_immediate = {imm16, 16'b0};
            default:                  o_immediate = {{16{imm16[15]}}, imm16};
        endcase
    end

    assign o_shamt     = {27'b0, i_inst[10:6]};
    assign o_jump_addr = {i_pc[31:28], 2'b00, i_inst[25:0]};  // Word-addressed target

    assign o_rs = i_inst[25:21];
    assign o_rt = i_inst[20:16];
    assign o_rd = i_inst[15:11];

endmodule

/* design/control_unit.sv */
module control_unit (
    input  id_pkg::inst_t i_inst,
    input  logic          i_stall,    // Bubble request
    output id_pkg::ctrl_t o_ctrl
);

    import id_pkg::*;

    opcode_t opcode;
    funct_t  funct;
    ctrl_t   ctrl_dec;

    assign opcode = i_inst[31:26];
    assign funct  = i_inst[5:0];

    always_comb begin
        ctrl_dec = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl_dec.reg_dest  = 1'b1;
                ctrl_dec.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: ctrl_dec.alu_op = ALU_ADD;
                    FN_SUBU: ctrl_dec.alu_op = ALU_SUB;
                    FN_AND:  ctrl_dec.alu_op = ALU_AND;
                    FN_OR:   ctrl_dec.alu_op = ALU_OR;
                    FN_XOR:  ctrl_dec.alu_op = ALU_XOR;
                    FN_NOR:  ctrl_dec.alu_op = ALU_NOR;
                    FN_SLT:  ctrl_dec.alu_op = ALU_SLT;
                    FN_SLL:  ctrl_dec.alu_op = ALU_SLL;
                    FN_SRL:  ctrl_dec.alu_op = ALU_SRL;
                    FN_JR: begin
                        ctrl_dec.jr_jalr   = 1'b1;
                        ctrl_dec.reg_write = 1'b0;   // Target only, no write
                    end
                    FN_JALR: begin
                        ctrl_dec.jr_jalr = 1'b1;
                        ctrl_dec.link    = 1'b1;     // rd <- PC+1
                    end
                    default: ctrl_dec = '0;          // Unknown funct
                endcase
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl_dec.alu_src   = 1'b1;
                ctrl_dec.reg_write = 1'b1;
                case (opcode)
                    OP_SLTI: ctrl_dec.alu_op = ALU_SLT;
                    OP_ANDI: ctrl_dec.alu_op = ALU_AND;
                    OP_ORI:  ctrl_dec.alu_op = ALU_OR;
                    OP_XORI: ctrl_dec.alu_op = ALU_XOR;
                    OP_LUI:  ctrl_dec.alu_op = ALU_LUI;
                    default: ctrl_dec.alu_op = ALU_ADD;
                endcase
            end
            OP_LB, OP_LH, OP_LW: begin
                ctrl_dec.alu_src     = 1'b1;
                ctrl_dec.alu_op      = ALU_ADD;     // Address calc
                ctrl_dec.mem_read    = 1'b1;
                ctrl_dec.mem_to_reg  = 1'b1;
                ctrl_dec.reg_write   = 1'b1;
                ctrl_dec.byte_en     = (opcode == OP_LB);
                ctrl_dec.halfword_en = (opcode == OP_LH);
                ctrl_dec.word_en     = (opcode == OP_LW);
            end
            OP_SB, OP_SH, OP_SW: begin
                ctrl_dec.alu_src     = 1'b1;
                ctrl_dec.alu_op      = ALU_ADD;
                ctrl_dec.mem_write   = 1'b1;
                ctrl_dec.byte_en     = (opcode == OP_SB);
                ctrl_dec.halfword_en = (opcode == OP_SH);
                ctrl_dec.word_en     = (opcode == OP_SW);
            end
            OP_BEQ, OP_BNE: begin
                ctrl_dec.alu_op    = ALU_SUB;       // Compare by subtraction
                ctrl_dec.branch    = 1'b1;
                ctrl_dec.branch_ne = (opcode == OP_BNE);
            end
            OP_J:   ctrl_dec.jump = 1'b1;
            OP_JAL: begin
                ctrl_dec.jump      = 1'b1;
                ctrl_dec.link      = 1'b1;          // r31 <- PC+1
                ctrl_dec.reg_write = 1'b1;
            end
            OP_HALT: ctrl_dec.hlt = 1'b1;
            default: ctrl_dec = '0;                 // Unknown opcode is a no-op
        endcase
        if (i_inst == '0) ctrl_dec = '0;           // Canonical NOP
    end

    assign o_ctrl = i_stall ? '0 : ctrl_dec;       // Bubble on stall

    always_comb begin
        a_width_onehot : assert ($onehot0({ctrl_dec.byte_en, ctrl_dec.halfword_en,
                                           ctrl_dec.word_en}))
            else $error("control_unit: more than one access width");
    end

endmodule

/* design/register_bank.sv */
module register_bank #(
    parameter bit P_WB_BYPASS = 1'b1
) (
    input  logic                i_clock,
    input  logic                i_arst_n,
    input  id_pkg::wb_t         i_wb,
    input  id_pkg::reg_addr_t   i_rs,
    input  id_pkg::reg_addr_t   i_rt,
    input  id_pkg::reg_addr_t   i_dbg_addr,
    output id_pkg::data_t       o_data_a,
    output id_pkg::data_t       o_data_b,
    output id_pkg::data_t       o_dbg_data
);

    import id_pkg::*;

    data_t regs [REG_COUNT];
    logic  wr_en;

    assign wr_en = i_wb.reg_write && (i_wb.addr != '0);  // r0 is hardwired

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.addr] <= i_wb.data;
        end
    end

    // Read with optional same-cycle forwarding from write-back
    function automatic data_t read_port(input reg_addr_t addr);
        data_t value;
        if (P_WB_BYPASS && wr_en && (i_wb.addr == addr))
            value = i_wb.data;
        else
            value = regs[addr];   // r0 reads its cleared entry
        return value;
    endfunction

    always_comb begin
        o_data_a = read_port(i_rs);
        o_data_b = read_port(i_rt);
    end

    assign o_dbg_data = regs[i_dbg_addr];  // Stored value only

    a_r0_zero : assert property (@(posedge i_clock) disable iff (!i_arst_n)
        regs[0] == '0)
        else $error("register_bank: r0 was written");

endmodule

/* design/if_id_latch.sv */
module if_id_latch (
    input  logic          i_clock,
    input  logic          i_arst_n,
    input  logic          i_enable,   // Debug unit run level
    input  logic          i_stall,    // Hazard hold
    input  id_pkg::inst_t i_inst,
    input  id_pkg::pc_t   i_pc,
    output id_pkg::inst_t o_inst,
    output id_pkg::pc_t   o_pc
);

    logic load;

    // Freeze on hazard or debug halt
    assign load = i_enable && !i_stall;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_inst <= '0;   // All-zero word is a NOP
            o_pc   <= '0;
        end else if (load) begin
            o_inst <= i_inst;
            o_pc   <= i_pc;
        end
    end

endmodule

/* design/id_pkg.sv */
package id_pkg;

    localparam int INST_W     = 32;
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int REG_COUNT  = 32;

    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [INST_W-1:0]     pc_t;       // PC+1, word units
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [FUNCT_W-1:0]    funct_t;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LB    = 6'h20;
    localparam opcode_t OP_LH    = 6'h21;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SB    = 6'h28;
    localparam opcode_t OP_SH    = 6'h29;
    localparam opcode_t OP_SW    = 6'h2b;
    localparam opcode_t OP_HALT  = 6'h3f;

    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_JALR = 6'h09;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_t;

    typedef struct packed {
        logic    reg_dest;     // 1 -> rd, 0 -> rt
        alu_op_t alu_op;
        logic    alu_src;      // 1 -> immediate
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    reg_write;
        logic    mem_to_reg;
        logic    jump;
        logic    jr_jalr;
        logic    link;         // Write PC+1 back
        logic    byte_en;
        logic    halfword_en;
        logic    word_en;
        logic    hlt;
    } ctrl_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t addr;
        data_t     data;
    } wb_t;

    typedef struct packed {
        ctrl_t     ctrl;
        pc_t       pc;
        data_t     data_a;
        data_t     data_b;
        data_t     immediate;
        data_t     shamt;
        pc_t       jump_addr;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
    } id_ex_t;

endpackage
